/* usb_bulk.f */
usb_bulk_pkg.sv
token_filter.sv
bulk_xfer_ctrl.sv
hsk_issuer.sv
bulk_in_path.sv
bulk_out_path.sv
usb_bulk_top.sv
tb_usb_bulk.sv

/* tb_usb_bulk.sv */
module tb_usb_bulk;
  timeunit 1ns;
  timeprecision 100ps;

  // Transactions run in total, and the worst case length of one of them
  localparam int NUM_XFER    = 12;
  localparam int XFER_CYCLES = 200;
  localparam int RESET_CYCLES = 8;
  localparam logic [6:0] DEV_ADDR = 7'h05;

  logic clock;
  logic reset;
  logic [6:0] usb_addr_i;
  usb_bulk_pkg::token_t tok_i;
  logic hsk_recv_i;
  usb_bulk_pkg::hsk_type_t hsk_type_i;
  usb_bulk_pkg::axis_byte_t rx_i;
  logic usb_tready_o;
  logic hsk_send_o;
  usb_bulk_pkg::hsk_type_t hsk_type_o;
  logic hsk_sent_i;
  logic usb_send_o;
  usb_bulk_pkg::pid_data_t usb_type_o;
  logic usb_busy_i;
  logic usb_sent_i;
  usb_bulk_pkg::axis_byte_t tx_o;
  logic usb_tready_i;
  logic blk_in_ready_i;
  logic blk_out_ready_i;
  logic blk_start_o;
  logic blk_cycle_o;
  usb_bulk_pkg::axis_byte_t blk_src_i;
  logic blk_tready_o;
  usb_bulk_pkg::axis_byte_t blk_snk_o;
  logic blk_tready_i;
  logic err_valid_o;
  usb_bulk_pkg::err_code_t err_code_o;

  // Scoreboard state
  integer seed = 32'h440402ee;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int hsk_rises = 0;
  int err_pulses = 0;
  int zdp_cnt = 0;
  int hsk_cnt = 0;
  logic seen_tok = 1'b0;
  logic zdp_mode = 1'b0;
  logic filter_mode = 1'b0;
  usb_bulk_pkg::pid_data_t exp_pid = usb_bulk_pkg::DATA0;
  usb_bulk_pkg::hsk_type_t exp_hsk = usb_bulk_pkg::HSK_ACK;
  usb_bulk_pkg::err_code_t exp_err = usb_bulk_pkg::ERR_NONE;
  logic [8:0] exp_snk[$];
  logic [8:0] exp_tx[$];

  usb_bulk_top #(
    .ENDPOINT(4'd1)
  ) i_usb_bulk_top (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Watchdog over the summed worst case of all transactions, times four
  initial begin
    #(4 * (RESET_CYCLES + NUM_XFER * XFER_CYCLES) * 10);
    $display("Timeout: the run did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  // Encoder model, busy from the send request until the packet is out
  always @(posedge clock) begin
    usb_sent_i <= 1'b0;
    usb_tready_i <= 1'b0;
    if (reset) begin
      usb_busy_i <= 1'b0;
    end else if (!usb_busy_i && usb_send_o && !usb_sent_i) begin
      usb_busy_i <= 1'b1;
      zdp_cnt <= 0;
      usb_tready_i <= ($random(seed) & 3) != 0;
    end else if (usb_busy_i) begin
      if (zdp_mode) begin
        zdp_cnt <= zdp_cnt + 1;
        if (zdp_cnt == 2) begin
          usb_sent_i <= 1'b1;
          usb_busy_i <= 1'b0;
        end
      end else if (tx_o.tvalid && usb_tready_i && tx_o.tlast) begin
        usb_sent_i <= 1'b1;
        usb_busy_i <= 1'b0;
      end else begin
        usb_tready_i <= ($random(seed) & 3) != 0;
      end
    end
  end

  // Host side of our handshake, confirmed two cycles after the request
  always @(posedge clock) begin
    hsk_sent_i <= 1'b0;
    if (hsk_send_o && !hsk_sent_i) begin
      hsk_cnt <= hsk_cnt + 1;
      if (hsk_cnt == 1) begin
        hsk_sent_i <= 1'b1;
        hsk_cnt <= 0;
      end
    end
  end

  // Sink stalls
  always @(posedge clock) begin
    blk_tready_i <= ($random(seed) & 3) != 0;
  end

  // Event counters and byte scoreboards
  always @(posedge clock) begin
    if (!reset) begin
      if (hsk_send_o && !$past(hsk_send_o)) hsk_rises <= hsk_rises + 1;
      if (err_valid_o) err_pulses <= err_pulses + 1;
      if (blk_snk_o.tvalid && blk_tready_i) begin
        assert (exp_snk.size() > 0) else begin
          errors++;
          $display("Sink received byte %h that was not expected", blk_snk_o.tdata);
        end
        if (exp_snk.size() > 0) begin
          assert ({blk_snk_o.tlast, blk_snk_o.tdata} == exp_snk[0]) else begin
            errors++;
            $display("FAILED blk_snk_o exp=%h got=%h", exp_snk[0],
                     {blk_snk_o.tlast, blk_snk_o.tdata});
          end
          void'(exp_snk.pop_front());
        end
      end
      if (tx_o.tvalid && usb_tready_i) begin
        assert (exp_tx.size() > 0 && {tx_o.tlast, tx_o.tdata} == exp_tx[0]) else begin
          errors++;
          $display("FAILED tx_o exp=%h got=%h", exp_tx.size() > 0 ? exp_tx[0] : 9'h0,
                   {tx_o.tlast, tx_o.tdata});
        end
        if (exp_tx.size() > 0) void'(exp_tx.pop_front());
      end
    end
  end

  // Quiet outputs until the first token
  assert property (@(posedge clock) disable iff (reset)
    !seen_tok |-> !(hsk_send_o || usb_send_o || tx_o.tvalid || blk_snk_o.tvalid ||
                    blk_start_o || blk_cycle_o || err_valid_o))
    else begin
      errors++;
      $display("An output was active before the first token");
    end

  // Streams hold their beat while stalled
  assert property (@(posedge clock) disable iff (reset)
    tx_o.tvalid && !usb_tready_i |=> $stable(tx_o))
    else begin
      errors++;
      $display("FAILED tx_o exp=%h got=%h", $past(tx_o), tx_o);
    end
  assert property (@(posedge clock) disable iff (reset)
    blk_snk_o.tvalid && !blk_tready_i |=> $stable(blk_snk_o))
    else begin
      errors++;
      $display("FAILED blk_snk_o exp=%h got=%h", $past(blk_snk_o), blk_snk_o);
    end

  // Data PID follows the toggle predicted by the scoreboard
  assert property (@(posedge clock) disable iff (reset)
    $rose(usb_send_o) |-> usb_type_o == exp_pid)
    else begin
      errors++;
      $display("FAILED usb_type_o exp=%h got=%h", exp_pid, usb_type_o);
    end
  assert property (@(posedge clock) disable iff (reset)
    $rose(hsk_send_o) |-> hsk_type_o == exp_hsk)
    else begin
      errors++;
      $display("FAILED hsk_type_o exp=%h got=%h", exp_hsk, hsk_type_o);
    end

  // Zero-data packet carries no byte
  assert property (@(posedge clock) disable iff (reset) !(zdp_mode && tx_o.tvalid))
    else begin
      errors++;
      $display("A byte appeared on tx_o during a zero-data packet");
    end

  // Transfer framing
  assert property (@(posedge clock) disable iff (reset) blk_start_o == $rose(blk_cycle_o))
    else begin
      errors++;
      $display("blk_start_o did not mark exactly the first transfer cycle");
    end
  assert property (@(posedge clock) disable iff (reset)
    $fell(blk_cycle_o) |-> $past(hsk_sent_i) || $past(hsk_recv_i))
    else begin
      errors++;
      $display("blk_cycle_o fell without a handshake before it");
    end
  assert property (@(posedge clock) disable iff (reset) !(filter_mode && blk_cycle_o))
    else begin
      errors++;
      $display("A refused token started a transfer");
    end

  // Error strobe is one cycle with the expected code
  assert property (@(posedge clock) disable iff (reset)
    err_valid_o |-> err_code_o == exp_err ##1 !err_valid_o)
    else begin
      errors++;
      $display("FAILED err_code_o exp=%h got=%h", exp_err, err_code_o);
    end

  task automatic send_token(usb_bulk_pkg::tok_type_t kind, logic [6:0] addr, logic [3:0] endp);
    seen_tok <= 1'b1;
    tok_i <= '{recv: 1'b1, kind: kind, addr: addr, endp: endp};
    @(posedge clock);
    tok_i.recv <= 1'b0;
  endtask

  task automatic wait_idle();
    while (blk_cycle_o) @(posedge clock);
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    if (errors == err_before) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", tests, name, errors - err_before);
    end
  endtask

  task automatic out_transfer(logic ready);
    int len;
    int e0;
    logic [7:0] pkt[$];
    e0 = errors;
    len = ($unsigned($random(seed)) % 8) + 1;
    for (int i = 0; i < len; i++) pkt.push_back(8'($random(seed)));
    if (ready) begin
      for (int i = 0; i < len; i++) exp_snk.push_back({i == len - 1, pkt[i]});
    end
    exp_hsk = ready ? usb_bulk_pkg::HSK_ACK : usb_bulk_pkg::HSK_NAK;
    hsk_rises = 0;
    blk_out_ready_i <= ready;
    send_token(usb_bulk_pkg::TOK_OUT, DEV_ADDR, 4'd1);
    while (!blk_cycle_o) @(posedge clock);
    // Host data packet, each byte held until taken
    for (int i = 0; i < len; i++) begin
      rx_i <= '{tvalid: 1'b1, tlast: i == len - 1, tdata: pkt[i]};
      @(posedge clock);
      while (!usb_tready_o) @(posedge clock);
    end
    rx_i.tvalid <= 1'b0;
    wait_idle();
    if (ready) exp_pid = exp_pid == usb_bulk_pkg::DATA0 ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0;
    assert (hsk_rises == 1 && exp_snk.size() == 0) else begin
      errors++;
      $display("OUT ended with %0d handshakes and %0d bytes missing", hsk_rises, exp_snk.size());
    end
    report_test(ready ? "out_ack" : "out_nak", e0);
  endtask

  task automatic in_transfer(logic ready);
    int len;
    int e0;
    logic [7:0] b;
    e0 = errors;
    len = ($unsigned($random(seed)) % 8) + 1;
    zdp_mode <= !ready;
    blk_in_ready_i <= ready;
    send_token(usb_bulk_pkg::TOK_IN, DEV_ADDR, 4'd1);
    if (ready) begin
      for (int i = 0; i < len; i++) begin
        b = 8'($random(seed));
        exp_tx.push_back({i == len - 1, b});
        blk_src_i <= '{tvalid: 1'b1, tlast: i == len - 1, tdata: b};
        @(posedge clock);
        while (!blk_tready_o) @(posedge clock);
      end
      blk_src_i.tvalid <= 1'b0;
    end else begin
      // Source offers a byte it has not declared ready, so it must stay put
      b = 8'($random(seed));
      blk_src_i <= '{tvalid: 1'b1, tlast: 1'b1, tdata: b};
    end
    while (!usb_sent_i) @(posedge clock);
    // Host acknowledges the data packet
    hsk_recv_i <= 1'b1;
    hsk_type_i <= usb_bulk_pkg::HSK_ACK;
    @(posedge clock);
    hsk_recv_i <= 1'b0;
    wait_idle();
    zdp_mode <= 1'b0;
    blk_src_i.tvalid <= 1'b0;
    exp_pid = exp_pid == usb_bulk_pkg::DATA0 ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0;
    assert (exp_tx.size() == 0) else begin
      errors++;
      $display("IN packet ended with %0d bytes not sent", exp_tx.size());
    end
    report_test(ready ? "in_data" : "in_zdp", e0);
  endtask

  task automatic filter_check(string name, usb_bulk_pkg::tok_type_t kind, logic [6:0] addr,
                              logic [3:0] endp, usb_bulk_pkg::err_code_t code, int pulses);
    int e0;
    e0 = errors;
    filter_mode <= 1'b1;
    exp_err <= code;
    err_pulses = 0;
    send_token(kind, addr, endp);
    repeat (6) @(posedge clock);
    filter_mode <= 1'b0;
    assert (err_pulses == pulses) else begin
      errors++;
      $display("FAILED err_valid_o pulses exp=%h got=%h", pulses, err_pulses);
    end
    report_test(name, e0);
  endtask

  initial begin
    int e0;
    reset <= 1'b1;
    usb_addr_i <= DEV_ADDR;
    tok_i <= '0;
    hsk_recv_i <= 1'b0;
    hsk_type_i <= usb_bulk_pkg::HSK_ACK;
    rx_i <= '0;
    blk_src_i <= '0;
    blk_in_ready_i <= 1'b0;
    blk_out_ready_i <= 1'b0;
    hsk_sent_i = 1'b0;
    usb_busy_i = 1'b0;
    usb_sent_i = 1'b0;
    usb_tready_i = 1'b0;
    blk_tready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    e0 = errors;
    repeat (10) @(posedge clock);
    report_test("reset", e0);
    in_transfer(1'b1);
    in_transfer(1'b1);
    out_transfer(1'b1);
    out_transfer(1'b0);
    in_transfer(1'b1);
    in_transfer(1'b0);
    in_transfer(1'b1);
    out_transfer(1'b1);
    filter_check("other_addr", usb_bulk_pkg::TOK_IN, 7'h06, 4'd1, usb_bulk_pkg::ERR_NONE, 0);
    filter_check("wrong_endp", usb_bulk_pkg::TOK_IN, DEV_ADDR, 4'd2, usb_bulk_pkg::ERR_ENDP, 1);
    filter_check("setup", usb_bulk_pkg::TOK_SETUP, DEV_ADDR, 4'd1, usb_bulk_pkg::ERR_TOKN, 1);
    $display("Tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* usb_bulk_top.sv */
module usb_bulk_top #(
  parameter logic [3:0] ENDPOINT = 4'd1
) (
  input  logic                     clock,
  input  logic                     reset,
  // Address assigned by the host
  input  logic [6:0]               usb_addr_i,
  // Decoder side
  input  usb_bulk_pkg::token_t     tok_i,
  input  logic                     hsk_recv_i,
  input  usb_bulk_pkg::hsk_type_t  hsk_type_i,
  input  usb_bulk_pkg::axis_byte_t rx_i,
  output logic                     usb_tready_o,
  // Encoder side
  output logic                     hsk_send_o,
  output usb_bulk_pkg::hsk_type_t  hsk_type_o,
  input  logic                     hsk_sent_i,
  output logic                     usb_send_o,
  output usb_bulk_pkg::pid_data_t  usb_type_o,
  input  logic                     usb_busy_i,
  input  logic                     usb_sent_i,
  output usb_bulk_pkg::axis_byte_t tx_o,
  input  logic                     usb_tready_i,
  // Bulk endpoint user side
  input  logic                     blk_in_ready_i,
  input  logic                     blk_out_ready_i,
  output logic                     blk_start_o,
  output logic                     blk_cycle_o,
  input  usb_bulk_pkg::axis_byte_t blk_src_i,
  output logic                     blk_tready_o,
  output usb_bulk_pkg::axis_byte_t blk_snk_o,
  input  logic                     blk_tready_i,
  // Refused tokens
  output logic                     err_valid_o,
  output usb_bulk_pkg::err_code_t  err_code_o
);

  // Filter to FSM
  logic tok_in;
  logic tok_out;

  // FSM to datapath
  logic in_tx_en;
  logic in_zdp_en;
  logic out_rx_en;
  logic ack_req;
  logic nak_req;
  usb_bulk_pkg::pid_data_t pid;

  // Datapath back to FSM
  logic tx_last;
  logic zdp_sent;
  logic rx_last;

  token_filter #(
    .ENDPOINT(ENDPOINT)
  ) i_token_filter (
    .clock      (clock),
    .reset      (reset),
    .usb_addr_i (usb_addr_i),
    .tok_i      (tok_i),
    .tok_in_o   (tok_in),
    .tok_out_o  (tok_out),
    .err_valid_o(err_valid_o),
    .err_code_o (err_code_o)
  );

  bulk_xfer_ctrl i_bulk_xfer_ctrl (
    .clock          (clock),
    .reset          (reset),
    .tok_in_i       (tok_in),
    .tok_out_i      (tok_out),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .tx_last_i      (tx_last),
    .zdp_sent_i     (zdp_sent),
    .rx_last_i      (rx_last),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_type_i     (hsk_type_i),
    .hsk_sent_i     (hsk_sent_i),
    .in_tx_en_o     (in_tx_en),
    .in_zdp_en_o    (in_zdp_en),
    .out_rx_en_o    (out_rx_en),
    .ack_req_o      (ack_req),
    .nak_req_o      (nak_req),
    .pid_o          (pid),
    .blk_start_o    (blk_start_o),
    .blk_cycle_o    (blk_cycle_o)
  );

  hsk_issuer i_hsk_issuer (
    .clock     (clock),
    .reset     (reset),
    .ack_req_i (ack_req),
    .nak_req_i (nak_req),
    .hsk_sent_i(hsk_sent_i),
    .hsk_send_o(hsk_send_o),
    .hsk_type_o(hsk_type_o)
  );

  bulk_in_path i_bulk_in_path (
    .clock       (clock),
    .reset       (reset),
    .in_tx_en_i  (in_tx_en),
    .in_zdp_en_i (in_zdp_en),
    .pid_i       (pid),
    .blk_src_i   (blk_src_i),
    .usb_tready_i(usb_tready_i),
    .usb_busy_i  (usb_busy_i),
    .usb_sent_i  (usb_sent_i),
    .blk_tready_o(blk_tready_o),
    .tx_o        (tx_o),
    .usb_send_o  (usb_send_o),
    .usb_type_o  (usb_type_o),
    .tx_last_o   (tx_last),
    .zdp_sent_o  (zdp_sent)
  );

  bulk_out_path i_bulk_out_path (
    .clock       (clock),
    .reset       (reset),
    .out_rx_en_i (out_rx_en),
    .rx_i        (rx_i),
    .blk_tready_i(blk_tready_i),
    .usb_tready_o(usb_tready_o),
    .blk_snk_o   (blk_snk_o),
    .rx_last_o   (rx_last)
  );

endmodule

/* bulk_out_path.sv */
module bulk_out_path (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     out_rx_en_i,
  // Received bytes from the decoder
  input  usb_bulk_pkg::axis_byte_t rx_i,
  output logic                     usb_tready_o,
  // Bulk sink
  output usb_bulk_pkg::axis_byte_t blk_snk_o,
  input  logic                     blk_tready_i,
  output logic                     rx_last_o
);

  logic last_q;

  // Sink sees data only in the OUT data stage
  assign blk_snk_o.tvalid = out_rx_en_i && rx_i.tvalid;
  assign blk_snk_o.tlast  = rx_i.tlast;
  assign blk_snk_o.tdata  = rx_i.tdata;

  // Outside the data stage bytes are swallowed
  assign usb_tready_o = out_rx_en_i ? blk_tready_i : 1'b1;

  // Pulse after the sink takes the last byte
  always_ff @(posedge clock) begin
    if (reset) begin
      last_q <= 1'b0;
    end else begin
      last_q <= blk_snk_o.tvalid && blk_tready_i && rx_i.tlast;
    end
  end

  assign rx_last_o = last_q;

endmodule

/* bulk_in_path.sv */
module bulk_in_path (
  input  logic                     clock,
  input  logic                     reset,
  // Data stage enables and current toggle
  input  logic                     in_tx_en_i,
  input  logic                     in_zdp_en_i,
  input  usb_bulk_pkg::pid_data_t  pid_i,
  // Bulk source
  input  usb_bulk_pkg::axis_byte_t blk_src_i,
  output logic                     blk_tready_o,
  // Packet encoder
  output usb_bulk_pkg::axis_byte_t tx_o,
  input  logic                     usb_tready_i,
  input  logic                     usb_busy_i,
  input  logic                     usb_sent_i,
  output logic                     usb_send_o,
  output usb_bulk_pkg::pid_data_t  usb_type_o,
  // Completion reports
  output logic                     tx_last_o,
  output logic                     zdp_sent_o
);

  // Skid register, output slot and spare slot
  logic       out_vld_q;
  logic       skid_vld_q;
  logic [8:0] out_pay_q;
  logic [8:0] skid_pay_q;
  logic       src_fire;
  logic       out_free;

  // Encoder request
  logic                    send_q;
  logic                    zero_q;
  logic                    issued_q;
  logic                    start_w;
  usb_bulk_pkg::pid_data_t type_q;

  // Accept only during the data stage and while the spare slot is empty
  assign blk_tready_o = in_tx_en_i && !skid_vld_q;
  assign src_fire     = blk_src_i.tvalid && blk_tready_o;
  // Output slot can take a new beat this cycle
  assign out_free     = !out_vld_q || usb_tready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_vld_q  <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (out_free) begin
      out_vld_q  <= skid_vld_q || src_fire;
      skid_vld_q <= 1'b0;
    end else if (src_fire) begin
      // Encoder stalled, park the beat
      skid_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      // Spare slot drains first to keep byte order
      if (skid_vld_q) begin
        out_pay_q <= skid_pay_q;
      end else if (src_fire) begin
        out_pay_q <= {blk_src_i.tlast, blk_src_i.tdata};
      end
    end else if (src_fire) begin
      skid_pay_q <= {blk_src_i.tlast, blk_src_i.tdata};
    end
  end

  assign tx_o.tvalid = out_vld_q;
  assign tx_o.tlast  = out_pay_q[8];
  assign tx_o.tdata  = out_pay_q[7:0];

  // Request once per data stage, on the first byte or for an empty packet
  assign start_w = !issued_q && (in_zdp_en_i || src_fire);

  always_ff @(posedge clock) begin
    if (reset) begin
      send_q   <= 1'b0;
      zero_q   <= 1'b0;
      issued_q <= 1'b0;
    end else begin
      // Re-arm once both data stages are over
      if (!in_tx_en_i && !in_zdp_en_i) begin
        issued_q <= 1'b0;
      end else if (start_w) begin
        issued_q <= 1'b1;
      end
      // Encoder has taken the request
      if (usb_busy_i || usb_sent_i) begin
        send_q <= 1'b0;
      end else if (start_w) begin
        send_q <= 1'b1;
      end
      if (start_w) begin
        zero_q <= in_zdp_en_i;
      end else if (usb_sent_i) begin
        zero_q <= 1'b0;
      end
    end
  end

  // PID captured with the request
  always_ff @(posedge clock) begin
    if (start_w) begin
      type_q <= pid_i;
    end
  end

  assign usb_send_o = send_q;
  assign usb_type_o = type_q;
  assign tx_last_o  = src_fire && blk_src_i.tlast;
  assign zdp_sent_o = zero_q && usb_sent_i;

endmodule

/* hsk_issuer.sv */
module hsk_issuer (
  input  logic                    clock,
  input  logic                    reset,
  // One-cycle requests from the FSM
  input  logic                    ack_req_i,
  input  logic                    nak_req_i,
  // Encoder confirms the handshake went out
  input  logic                    hsk_sent_i,
  output logic                    hsk_send_o,
  output usb_bulk_pkg::hsk_type_t hsk_type_o
);

  logic                    send_q;
  logic                    req_any;
  usb_bulk_pkg::hsk_type_t type_q;

  // A new request only counts when nothing is pending
  assign req_any = !send_q && (ack_req_i || nak_req_i);

  // Send strobe stays up until the encoder reports it sent
  always_ff @(posedge clock) begin
    if (reset) begin
      send_q <= 1'b0;
    end else if (send_q) begin
      if (hsk_sent_i) begin
        send_q <= 1'b0;
      end
    end else if (req_any) begin
      send_q <= 1'b1;
    end
  end

  // Kind latched with the request, held while pending
  always_ff @(posedge clock) begin
    if (req_any) begin
      type_q <= nak_req_i ? usb_bulk_pkg::HSK_NAK : usb_bulk_pkg::HSK_ACK;
    end
  end

  assign hsk_send_o = send_q;
  assign hsk_type_o = type_q;

endmodule

/* bulk_xfer_ctrl.sv */
module bulk_xfer_ctrl (
  input  logic                    clock,
  input  logic                    reset,
  // Token pulses from the filter
  input  logic                    tok_in_i,
  input  logic                    tok_out_i,
  // Endpoint readiness, sampled when the token arrives
  input  logic                    blk_in_ready_i,
  input  logic                    blk_out_ready_i,
  // Data stage completion from the datapath
  input  logic                    tx_last_i,
  input  logic                    zdp_sent_i,
  input  logic                    rx_last_i,
  // Handshake stage
  input  logic                    hsk_recv_i,
  input  usb_bulk_pkg::hsk_type_t hsk_type_i,
  input  logic                    hsk_sent_i,
  // Datapath controls
  output logic                    in_tx_en_o,
  output logic                    in_zdp_en_o,
  output logic                    out_rx_en_o,
  output logic                    ack_req_o,
  output logic                    nak_req_o,
  output usb_bulk_pkg::pid_data_t pid_o,
  // Transfer framing for the endpoint user
  output logic                    blk_start_o,
  output logic                    blk_cycle_o
);

  usb_bulk_pkg::xfer_state_t state_q;
  usb_bulk_pkg::pid_data_t   pid_q;
  logic                      start_q;
  logic                      tok_any;

  assign tok_any = tok_in_i || tok_out_i;

  // Datapath enables decoded from the state
  assign in_tx_en_o  = state_q == usb_bulk_pkg::ST_DATI_TX;
  assign in_zdp_en_o = state_q == usb_bulk_pkg::ST_DATI_ZDP;
  assign out_rx_en_o = state_q == usb_bulk_pkg::ST_DATO_RX;

  // ACK once the last OUT byte has reached the sink
  assign ack_req_o = state_q == usb_bulk_pkg::ST_DATO_RX && rx_last_i;
  // NAK straight from the token when the sink has no room
  assign nak_req_o = state_q == usb_bulk_pkg::ST_IDLE && tok_out_i && !blk_out_ready_i;

  assign pid_o       = pid_q;
  assign blk_start_o = start_q;
  assign blk_cycle_o = state_q != usb_bulk_pkg::ST_IDLE;

  // Transaction FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_bulk_pkg::ST_IDLE;
    end else begin
      case (state_q)
        usb_bulk_pkg::ST_IDLE: begin
          // Pick the data stage from the token and endpoint readiness
          if (tok_in_i) begin
            state_q <= blk_in_ready_i ? usb_bulk_pkg::ST_DATI_TX : usb_bulk_pkg::ST_DATI_ZDP;
          end else if (tok_out_i) begin
            state_q <= blk_out_ready_i ? usb_bulk_pkg::ST_DATO_RX : usb_bulk_pkg::ST_DATO_NAK;
          end
        end
        usb_bulk_pkg::ST_DATI_TX: begin
          // Source has handed over its last byte
          if (tx_last_i) begin
            state_q <= usb_bulk_pkg::ST_DATI_ACK;
          end
        end
        usb_bulk_pkg::ST_DATI_ZDP: begin
          // Empty packet is out on the bus
          if (zdp_sent_i) begin
            state_q <= usb_bulk_pkg::ST_DATI_ACK;
          end
        end
        usb_bulk_pkg::ST_DATI_ACK: begin
          // Any host handshake ends the IN transaction
          if (hsk_recv_i) begin
            state_q <= usb_bulk_pkg::ST_IDLE;
          end
        end
        usb_bulk_pkg::ST_DATO_RX: begin
          if (rx_last_i) begin
            state_q <= usb_bulk_pkg::ST_DATO_ACK;
          end
        end
        usb_bulk_pkg::ST_DATO_ACK, usb_bulk_pkg::ST_DATO_NAK: begin
          // Wait for the encoder to put our handshake out
          if (hsk_sent_i) begin
            state_q <= usb_bulk_pkg::ST_IDLE;
          end
        end
        default: begin
          state_q <= usb_bulk_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Start strobe lines up with the first cycle out of IDLE
  always_ff @(posedge clock) begin
    if (reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= state_q == usb_bulk_pkg::ST_IDLE && tok_any;
    end
  end

  // Data toggle, advanced only by acknowledged packets
  always_ff @(posedge clock) begin
    if (reset) begin
      pid_q <= usb_bulk_pkg::DATA0;
    end else if (state_q == usb_bulk_pkg::ST_DATI_ACK && hsk_recv_i &&
                 hsk_type_i == usb_bulk_pkg::HSK_ACK) begin
      pid_q <= pid_q == usb_bulk_pkg::DATA0 ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0;
    end else if (state_q == usb_bulk_pkg::ST_DATO_ACK && hsk_sent_i) begin
      // Our own ACK on OUT data counts once it has been sent
      pid_q <= pid_q == usb_bulk_pkg::DATA0 ? usb_bulk_pkg::DATA1 : usb_bulk_pkg::DATA0;
    end
  end

endmodule

/* token_filter.sv */
module token_filter #(
  parameter logic [3:0] ENDPOINT = 4'd1
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [6:0]              usb_addr_i,
  input  usb_bulk_pkg::token_t    tok_i,
  output logic                    tok_in_o,
  output logic                    tok_out_o,
  output logic                    err_valid_o,
  output usb_bulk_pkg::err_code_t err_code_o
);

  logic addr_hit;
  logic endp_hit;
  logic is_bulk;
  logic tok_in_q;
  logic tok_out_q;
  logic err_valid_q;
  usb_bulk_pkg::err_code_t err_code_q;

  // Only tokens for our address get any reaction
  assign addr_hit = tok_i.recv && tok_i.addr == usb_addr_i;
  assign endp_hit = tok_i.endp == ENDPOINT;
  // SOF and SETUP are not served by a bulk endpoint
  assign is_bulk = tok_i.kind == usb_bulk_pkg::TOK_IN || tok_i.kind == usb_bulk_pkg::TOK_OUT;

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_in_q    <= 1'b0;
      tok_out_q   <= 1'b0;
      err_valid_q <= 1'b0;
      err_code_q  <= usb_bulk_pkg::ERR_NONE;
    end else begin
      tok_in_q  <= addr_hit && endp_hit && tok_i.kind == usb_bulk_pkg::TOK_IN;
      tok_out_q <= addr_hit && endp_hit && tok_i.kind == usb_bulk_pkg::TOK_OUT;
      // One-cycle error strobe for anything else sent to us
      err_valid_q <= addr_hit && !(is_bulk && endp_hit);
      if (addr_hit && !is_bulk) begin
        err_code_q <= usb_bulk_pkg::ERR_TOKN;
      end else if (addr_hit && !endp_hit) begin
        err_code_q <= usb_bulk_pkg::ERR_ENDP;
      end else begin
        err_code_q <= usb_bulk_pkg::ERR_NONE;
      end
    end
  end

  assign tok_in_o    = tok_in_q;
  assign tok_out_o   = tok_out_q;
  assign err_valid_o = err_valid_q;
  assign err_code_o  = err_code_q;

endmodule

/* usb_bulk_pkg.sv */
package usb_bulk_pkg;

  // Token PIDs as reported by the packet decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_t;

  // Handshake PIDs, to and from the host
  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_t;

  // Data PIDs, only the two used by full-speed bulk
  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } pid_data_t;

  // Error codes for tokens this device refuses to serve
  typedef enum logic [2:0] {
    ERR_NONE = 3'h0,
    ERR_TOKN = 3'h3,
    ERR_ENDP = 3'h5
  } err_code_t;

  // Token report from the decoder, valid while recv is high
  typedef struct packed {
    logic      recv;
    tok_type_t kind;
    logic [6:0] addr;
    logic [3:0] endp;
  } token_t;

  // One beat of a byte stream
  // Ready travels the other way on its own port
  typedef struct packed {
    logic       tvalid;
    logic       tlast;
    logic [7:0] tdata;
  } axis_byte_t;

  // Bulk transaction states, one-hot
  typedef enum logic [6:0] {
    ST_IDLE     = 7'h01,
    ST_DATI_TX  = 7'h02,
    ST_DATI_ZDP = 7'h04,
    ST_DATI_ACK = 7'h08,
    ST_DATO_RX  = 7'h10,
    ST_DATO_ACK = 7'h20,
    ST_DATO_NAK = 7'h40
  } xfer_state_t;

endpackage
